// ==== rtl/mdu_pkg.sv ====
`default_nettype none

package mdu_pkg;

    // datapath widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;   // x0..x31
    localparam int ID_W       = 2;   // 4 scoreboard entries
    localparam int OP_W       = 3;

    // multiplier ops, bit 2 clear
    localparam logic [OP_W-1:0] OP_MUL   = 3'b000;  // low half
    localparam logic [OP_W-1:0] OP_MULH  = 3'b001;  // high half, signed x signed
    localparam logic [OP_W-1:0] OP_MULHU = 3'b011;  // high half, unsigned

    // divider ops, bit 2 set
    localparam logic [OP_W-1:0] OP_DIV   = 3'b100;
    localparam logic [OP_W-1:0] OP_DIVU  = 3'b101;
    localparam logic [OP_W-1:0] OP_REM   = 3'b110;
    localparam logic [OP_W-1:0] OP_REMU  = 3'b111;

endpackage

`default_nettype wire

// ==== rtl/long_hazard_unit.sv ====
`default_nettype none

module long_hazard_unit #(
    parameter int ID_W_P = mdu_pkg::ID_W
) (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            inst_valid_i,    // long op offered
    input  wire                            op_is_div_i,     // op bit 2
    input  wire [mdu_pkg::REG_ADDR_W-1:0]  rd_i,
    input  wire [mdu_pkg::REG_ADDR_W-1:0]  rs1_i,
    input  wire [mdu_pkg::REG_ADDR_W-1:0]  rs2_i,
    input  wire                            rd_we_i,
    input  wire                            mul_ready_i,
    input  wire                            div_ready_i,
    input  wire                            commit_valid_i,  // writeback accepted
    input  wire [ID_W_P-1:0]               commit_id_i,
    output logic                           stall_o,
    output logic                           issue_o,         // single fire strobe
    output logic [ID_W_P-1:0]              issue_id_o,
    output logic                           busy_o
);

    localparam int ENTRIES = 1 << ID_W_P;

    logic [ENTRIES-1:0]              valid_q;        // live entries
    logic [mdu_pkg::REG_ADDR_W-1:0]  rd_q [ENTRIES]; // destination per entry
    logic                            raw_hit;
    logic                            waw_hit;
    logic                            table_full;
    logic                            unit_busy;
    logic                            rs1_chk;
    logic                            rs2_chk;
    logic                            rd_chk;

    // x0 never conflicts
    assign rs1_chk = (rs1_i != '0);
    assign rs2_chk = (rs2_i != '0);
    assign rd_chk  = rd_we_i && (rd_i != '0);

    always_comb begin
        raw_hit = 1'b0;
        waw_hit = 1'b0;
        for (int i = 0; i < ENTRIES; i++) begin
            // an entry retiring this cycle is already out of the way
            if (valid_q[i] && !(commit_valid_i && commit_id_i == ID_W_P'(i))) begin
                if ((rs1_chk && rs1_i == rd_q[i]) || (rs2_chk && rs2_i == rd_q[i])) begin
                    raw_hit = 1'b1;
                end
                if (rd_chk && rd_i == rd_q[i]) begin
                    waw_hit = 1'b1;
                end
            end
        end
    end

    assign table_full = &valid_q;  // freed slot only usable next cycle
    assign unit_busy  = op_is_div_i ? !div_ready_i : !mul_ready_i;
    assign stall_o    = raw_hit || waw_hit || table_full || unit_busy;
    assign issue_o    = inst_valid_i && !stall_o;
    assign busy_o     = |valid_q;

    // lowest free entry, scan top down so the last hit wins
    always_comb begin
        issue_id_o = '0;
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                issue_id_o = ID_W_P'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            if (commit_valid_i) begin
                valid_q[commit_id_i] <= 1'b0;
            end
            if (issue_o) begin
                valid_q[issue_id_o] <= 1'b1;  // never the committing slot, it is live
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_o) begin
            rd_q[issue_id_o] <= rd_i;
        end
    end

    // arbiter only commits ids handed out here
    a_commit_live: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid_i |-> valid_q[commit_id_i])
        else $error("commit to free entry %0d", commit_id_i);

    // issue lands in a free slot and never under stall
    a_issue_clean: assert property (@(posedge clk) disable iff (!rst_n)
        issue_o |-> !stall_o && !valid_q[issue_id_o])
        else $error("issue into entry %0d while blocked", issue_id_o);

endmodule

`default_nettype wire

// ==== rtl/mul_unit.sv ====
`default_nettype none

module mul_unit #(
    parameter int XLEN_P = mdu_pkg::XLEN,
    parameter int ID_W_P = mdu_pkg::ID_W
) (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            issue_i,
    input  wire [mdu_pkg::OP_W-1:0]        op_i,
    input  wire [XLEN_P-1:0]               opa_i,
    input  wire [XLEN_P-1:0]               opb_i,
    input  wire [mdu_pkg::REG_ADDR_W-1:0]  rd_i,
    input  wire [ID_W_P-1:0]               id_i,
    input  wire                            grant_i,   // writeback taken
    output logic                           ready_o,
    output logic                           valid_o,   // stage 3 full
    output logic [XLEN_P-1:0]              result_o,
    output logic [mdu_pkg::REG_ADDR_W-1:0] rd_o,
    output logic [ID_W_P-1:0]              id_o
);

    localparam int EW = XLEN_P + 1;  // one extra sign bit covers MULHU

    logic                            advance;
    logic                            accept;
    logic                            a_sgn;
    logic                            b_sgn;
    logic                            v1_q, hi1_q;      // stage 1
    logic [EW-1:0]                   a1_q, b1_q;
    logic [mdu_pkg::REG_ADDR_W-1:0]  rd1_q, rd2_q;
    logic [ID_W_P-1:0]               id1_q, id2_q;
    logic                            v2_q, hi2_q;      // stage 2
    logic signed [2*EW-1:0]          prod2_q;

    assign advance = !valid_o || grant_i;   // whole pipe moves or holds
    assign ready_o = advance;
    assign accept  = issue_i && !op_i[2];   // MUL family only
    assign a_sgn   = (op_i == mdu_pkg::OP_MULH) && opa_i[XLEN_P-1];
    assign b_sgn   = (op_i == mdu_pkg::OP_MULH) && opb_i[XLEN_P-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v1_q    <= 1'b0;
            v2_q    <= 1'b0;
            valid_o <= 1'b0;
        end else if (advance) begin
            v1_q    <= accept;
            v2_q    <= v1_q;
            valid_o <= v2_q;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            a1_q     <= {a_sgn, opa_i};
            b1_q     <= {b_sgn, opb_i};
            hi1_q    <= (op_i != mdu_pkg::OP_MUL);
            rd1_q    <= rd_i;
            id1_q    <= id_i;
            prod2_q  <= $signed(a1_q) * $signed(b1_q);  // full 2*EW product
            hi2_q    <= hi1_q;
            rd2_q    <= rd1_q;
            id2_q    <= id1_q;
            result_o <= hi2_q ? prod2_q[2*XLEN_P-1:XLEN_P] : prod2_q[XLEN_P-1:0];
            rd_o     <= rd2_q;
            id_o     <= id2_q;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/div_unit.sv ====
`default_nettype none

module div_unit #(
    parameter int XLEN_P = mdu_pkg::XLEN,
    parameter int ID_W_P = mdu_pkg::ID_W
) (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            issue_i,
    input  wire [mdu_pkg::OP_W-1:0]        op_i,
    input  wire [XLEN_P-1:0]               opa_i,     // dividend
    input  wire [XLEN_P-1:0]               opb_i,     // divisor
    input  wire [mdu_pkg::REG_ADDR_W-1:0]  rd_i,
    input  wire [ID_W_P-1:0]               id_i,
    input  wire                            grant_i,
    output logic                           ready_o,   // idle only
    output logic                           valid_o,
    output logic [XLEN_P-1:0]              result_o,
    output logic [mdu_pkg::REG_ADDR_W-1:0] rd_o,
    output logic [ID_W_P-1:0]              id_o
);

    localparam int CNT_W = $clog2(XLEN_P + 1);

    logic               accept;
    logic               sgn;
    logic               a_neg;
    logic               b_neg;
    logic               busy_q;        // iterating
    logic               neg_quo_q;     // flip quotient at the end
    logic               neg_rem_q;     // remainder follows dividend sign
    logic               rem_sel_q;     // REM/REMU
    logic [CNT_W-1:0]   cnt_q;         // iterations left
    logic [XLEN_P-1:0]  quo_q;         // dividend shifts out, quotient shifts in
    logic [XLEN_P-1:0]  rem_q;
    logic [XLEN_P-1:0]  dvs_q;         // |divisor|
    logic [XLEN_P:0]    rem_sh;        // partial remainder after shift
    logic               ge;            // trial subtract fits

    assign accept  = issue_i && op_i[2];
    assign sgn     = (op_i == mdu_pkg::OP_DIV) || (op_i == mdu_pkg::OP_REM);
    assign a_neg   = sgn && opa_i[XLEN_P-1];
    assign b_neg   = sgn && opb_i[XLEN_P-1];
    assign ready_o = !busy_q && !valid_o;

    assign rem_sh = {rem_q, quo_q[XLEN_P-1]};
    assign ge     = rem_sh >= {1'b0, dvs_q};   // always true on divide by zero

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q  <= 1'b0;
            valid_o <= 1'b0;
            cnt_q   <= '0;
        end else if (accept) begin
            busy_q <= 1'b1;
            cnt_q  <= CNT_W'(XLEN_P);
        end else if (busy_q) begin
            cnt_q <= cnt_q - 1'b1;
            if (cnt_q == CNT_W'(1)) begin  // last step, result up next cycle
                busy_q  <= 1'b0;
                valid_o <= 1'b1;
            end
        end else if (grant_i) begin
            valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            quo_q     <= a_neg ? -opa_i : opa_i;
            dvs_q     <= b_neg ? -opb_i : opb_i;
            rem_q     <= '0;
            // x/0 keeps all ones; MIN/-1 gives MIN with no fixup
            neg_quo_q <= (a_neg ^ b_neg) && (opb_i != '0);
            neg_rem_q <= a_neg;
            rem_sel_q <= (op_i == mdu_pkg::OP_REM) || (op_i == mdu_pkg::OP_REMU);
            rd_o      <= rd_i;
            id_o      <= id_i;
        end else if (busy_q) begin
            quo_q <= {quo_q[XLEN_P-2:0], ge};
            rem_q <= ge ? XLEN_P'(rem_sh - {1'b0, dvs_q}) : rem_sh[XLEN_P-1:0];
        end
    end

    // sign fixup, x/0 leaves the dividend in rem
    always_comb begin
        if (rem_sel_q) begin
            result_o = neg_rem_q ? -rem_q : rem_q;
        end else begin
            result_o = neg_quo_q ? -quo_q : quo_q;
        end
    end

    // scoreboard must hold divides off while this one runs
    a_no_issue_busy: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> !busy_q && !valid_o)
        else $error("divide issued while divider busy");

endmodule

`default_nettype wire

// ==== rtl/wb_arbiter.sv ====
`default_nettype none

module wb_arbiter #(
    parameter int XLEN_P = mdu_pkg::XLEN,
    parameter int ID_W_P = mdu_pkg::ID_W
) (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            mul_valid_i,
    input  wire [XLEN_P-1:0]               mul_result_i,
    input  wire [mdu_pkg::REG_ADDR_W-1:0]  mul_rd_i,
    input  wire [ID_W_P-1:0]               mul_id_i,
    input  wire                            div_valid_i,
    input  wire [XLEN_P-1:0]               div_result_i,
    input  wire [mdu_pkg::REG_ADDR_W-1:0]  div_rd_i,
    input  wire [ID_W_P-1:0]               div_id_i,
    input  wire                            wb_ready_i,
    output logic                           mul_grant_o,
    output logic                           div_grant_o,
    output logic                           wb_valid_o,
    output logic [mdu_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [XLEN_P-1:0]              wb_data_o,
    output logic                           commit_valid_o,  // frees scoreboard slot
    output logic [ID_W_P-1:0]              commit_id_o
);

    logic last_div_q;   // divider won the last writeback
    logic hold_q;       // port stalled last cycle, keep the same winner
    logic hold_div_q;
    logic rr_div;
    logic pick_div;
    logic fire;

    // both requesting: the unit that did not win last goes first
    assign rr_div   = div_valid_i && (!mul_valid_i || !last_div_q);
    assign pick_div = hold_q ? hold_div_q : rr_div;

    assign wb_valid_o = mul_valid_i || div_valid_i;
    assign wb_rd_o    = pick_div ? div_rd_i : mul_rd_i;
    assign wb_data_o  = pick_div ? div_result_i : mul_result_i;
    assign fire       = wb_valid_o && wb_ready_i;

    assign mul_grant_o    = fire && !pick_div;
    assign div_grant_o    = fire && pick_div;
    assign commit_valid_o = fire;
    assign commit_id_o    = pick_div ? div_id_i : mul_id_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_div_q <= 1'b1;   // mul gets first pick
            hold_q     <= 1'b0;
            hold_div_q <= 1'b0;
        end else begin
            hold_q     <= wb_valid_o && !wb_ready_i;
            hold_div_q <= pick_div;
            if (fire) begin
                last_div_q <= pick_div;
            end
        end
    end

    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(mul_grant_o && div_grant_o))
        else $error("both units granted");

    // units keep valid up until their grant
    a_grant_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (mul_grant_o |-> mul_valid_i) and (div_grant_o |-> div_valid_i))
        else $error("grant to idle unit");

endmodule

`default_nettype wire

// ==== rtl/mdu_top.sv ====
`default_nettype none

module mdu_top #(
    parameter int XLEN_P = mdu_pkg::XLEN,
    parameter int ID_W_P = mdu_pkg::ID_W
) (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            inst_valid_i,
    input  wire [mdu_pkg::OP_W-1:0]        op_i,
    input  wire [mdu_pkg::REG_ADDR_W-1:0]  rd_i,
    input  wire [mdu_pkg::REG_ADDR_W-1:0]  rs1_i,
    input  wire [mdu_pkg::REG_ADDR_W-1:0]  rs2_i,
    input  wire                            rd_we_i,
    input  wire [XLEN_P-1:0]               opa_i,
    input  wire [XLEN_P-1:0]               opb_i,
    input  wire                            wb_ready_i,
    output wire                            stall_o,
    output wire                            wb_valid_o,
    output wire [mdu_pkg::REG_ADDR_W-1:0]  wb_rd_o,
    output wire [XLEN_P-1:0]               wb_data_o,
    output wire                            busy_o
);

    wire                            issue;
    wire [ID_W_P-1:0]               issue_id;
    wire                            commit_valid;
    wire [ID_W_P-1:0]               commit_id;
    wire                            mul_ready, mul_valid, mul_grant;
    wire [XLEN_P-1:0]               mul_result;
    wire [mdu_pkg::REG_ADDR_W-1:0]  mul_rd;
    wire [ID_W_P-1:0]               mul_id;
    wire                            div_ready, div_valid, div_grant;
    wire [XLEN_P-1:0]               div_result;
    wire [mdu_pkg::REG_ADDR_W-1:0]  div_rd;
    wire [ID_W_P-1:0]               div_id;

    long_hazard_unit #(.ID_W_P(ID_W_P)) u_hazard (
        .clk(clk), .rst_n(rst_n),
        .inst_valid_i(inst_valid_i), .op_is_div_i(op_i[2]),
        .rd_i(rd_i), .rs1_i(rs1_i), .rs2_i(rs2_i), .rd_we_i(rd_we_i),
        .mul_ready_i(mul_ready), .div_ready_i(div_ready),
        .commit_valid_i(commit_valid), .commit_id_i(commit_id),
        .stall_o(stall_o), .issue_o(issue), .issue_id_o(issue_id), .busy_o(busy_o)
    );

    // op bit 2 steers the issue strobe
    mul_unit #(.XLEN_P(XLEN_P), .ID_W_P(ID_W_P)) u_mul (
        .clk(clk), .rst_n(rst_n), .issue_i(issue && !op_i[2]), .op_i(op_i),
        .opa_i(opa_i), .opb_i(opb_i), .rd_i(rd_i), .id_i(issue_id), .grant_i(mul_grant),
        .ready_o(mul_ready), .valid_o(mul_valid), .result_o(mul_result),
        .rd_o(mul_rd), .id_o(mul_id)
    );

    div_unit #(.XLEN_P(XLEN_P), .ID_W_P(ID_W_P)) u_div (
        .clk(clk), .rst_n(rst_n), .issue_i(issue && op_i[2]), .op_i(op_i),
        .opa_i(opa_i), .opb_i(opb_i), .rd_i(rd_i), .id_i(issue_id), .grant_i(div_grant),
        .ready_o(div_ready), .valid_o(div_valid), .result_o(div_result),
        .rd_o(div_rd), .id_o(div_id)
    );

    wb_arbiter #(.XLEN_P(XLEN_P), .ID_W_P(ID_W_P)) u_arb (
        .clk(clk), .rst_n(rst_n),
        .mul_valid_i(mul_valid), .mul_result_i(mul_result),
        .mul_rd_i(mul_rd), .mul_id_i(mul_id),
        .div_valid_i(div_valid), .div_result_i(div_result),
        .div_rd_i(div_rd), .div_id_i(div_id),
        .wb_ready_i(wb_ready_i),
        .mul_grant_o(mul_grant), .div_grant_o(div_grant),
        .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o),
        .commit_valid_o(commit_valid), .commit_id_o(commit_id)   // back to scoreboard
    );

endmodule

`default_nettype wire

// ==== testbench/tb_mdu_top.sv ====
`default_nettype none

module tb_mdu_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int XLEN    = mdu_pkg::XLEN;
    localparam int RW      = mdu_pkg::REG_ADDR_W;
    localparam int REGS    = 1 << RW;
    localparam int ENTRIES = 1 << mdu_pkg::ID_W;   // scoreboard depth
    localparam int N_INST  = 300;
    localparam int LIMIT   = N_INST * 40 + 500;    // cycles before giving up

    logic            clk = 1'b0;
    logic            rst_n;
    logic            inst_valid_i;
    logic [2:0]      op_i;
    logic [RW-1:0]   rd_i;
    logic [RW-1:0]   rs1_i;
    logic [RW-1:0]   rs2_i;
    logic            rd_we_i;
    logic [XLEN-1:0] opa_i;
    logic [XLEN-1:0] opb_i;
    logic            wb_ready_i;
    logic            stall_o;
    logic            wb_valid_o;
    logic [RW-1:0]   wb_rd_o;
    logic [XLEN-1:0] wb_data_o;
    logic            busy_o;

    // in-flight model, one slot per destination register
    logic            fl_valid [REGS];
    logic [2:0]      fl_op [REGS];
    logic [XLEN-1:0] fl_a [REGS];
    logic [XLEN-1:0] fl_b [REGS];
    int              fl_order [REGS];   // issue number
    int              n_flight = 0;
    int              n_issued = 0;
    int              err_data = 0;
    int              err_hazard = 0;
    int              err_proto = 0;
    int              seed = 75;
    int              cycles = 0;
    int              bp_pct = 0;         // percent of cycles with wb_ready low
    string           test_name = "reset";
    logic            hold_q = 1'b0;      // port was stalled at the last sample
    logic [RW-1:0]   prev_rd;
    logic [XLEN-1:0] prev_data;

    always #4 clk = ~clk;

    mdu_top u_dut (
        .clk(clk), .rst_n(rst_n), .inst_valid_i(inst_valid_i), .op_i(op_i),
        .rd_i(rd_i), .rs1_i(rs1_i), .rs2_i(rs2_i), .rd_we_i(rd_we_i),
        .opa_i(opa_i), .opb_i(opb_i), .wb_ready_i(wb_ready_i),
        .stall_o(stall_o), .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o),
        .wb_data_o(wb_data_o), .busy_o(busy_o)
    );

    // expected result straight from the RV32M rules
    function automatic logic [XLEN-1:0] mdu_ref(input logic [2:0] op,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        logic signed [2*XLEN-1:0] sprod;
        logic [2*XLEN-1:0]        uprod;
        logic                     ovf;
        logic [XLEN-1:0]          sq;
        logic [XLEN-1:0]          sr;
        logic [XLEN-1:0]          r;
        sprod = $signed(a) * $signed(b);
        uprod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        ovf   = (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1);  // MIN / -1
        sq    = '1;   // x/0 quotient
        sr    = a;    // x/0 remainder
        if (ovf) begin
            sq = a;
            sr = '0;
        end else if (b != '0) begin
            sq = $signed(a) / $signed(b);   // truncates toward zero
            sr = $signed(a) % $signed(b);   // sign of dividend
        end
        case (op)
            mdu_pkg::OP_MUL:   r = sprod[XLEN-1:0];
            mdu_pkg::OP_MULH:  r = sprod[2*XLEN-1:XLEN];
            mdu_pkg::OP_MULHU: r = uprod[2*XLEN-1:XLEN];
            mdu_pkg::OP_DIV:   r = sq;
            mdu_pkg::OP_REM:   r = sr;
            mdu_pkg::OP_DIVU:  r = (b == '0) ? '1 : a / b;
            mdu_pkg::OP_REMU:  r = (b == '0) ? a : a % b;
            default:           r = 'x;
        endcase
        return r;
    endfunction

    // register still owed a result after this cycle's writeback
    function automatic logic reg_pending(input logic [RW-1:0] r, input logic fire);
        return fl_valid[r] && !(fire && wb_rd_o == r);
    endfunction

    function automatic logic [XLEN-1:0] rand_word();
        int pick;
        pick = $unsigned($random(seed)) % 8;
        case (pick)
            0:       return '0;
            1:       return '1;
            2:       return {1'b1, {(XLEN-1){1'b0}}};   // most negative
            default: return $random(seed);
        endcase
    endfunction

    // kind 0 mul family, 1 div family, else any
    function automatic logic [2:0] rand_op(input int kind);
        int k;
        if (kind == 0) k = $unsigned($random(seed)) % 3;
        else if (kind == 1) k = 3 + $unsigned($random(seed)) % 4;
        else k = $unsigned($random(seed)) % 7;
        case (k)
            0:       return mdu_pkg::OP_MUL;
            1:       return mdu_pkg::OP_MULH;
            2:       return mdu_pkg::OP_MULHU;
            3:       return mdu_pkg::OP_DIV;
            4:       return mdu_pkg::OP_DIVU;
            5:       return mdu_pkg::OP_REM;
            default: return mdu_pkg::OP_REMU;
        endcase
    endfunction

    task automatic step_cycle();
        @(posedge clk);
        #1;
        wb_ready_i = ($unsigned($random(seed)) % 100) >= bp_pct;
    endtask

    task automatic run_phase(input string name, input int count, input int kind,
                             input int regs, input int bp, input logic corner);
        logic took;
        test_name = name;
        bp_pct    = bp;
        for (int i = 0; i < count; i++) begin
            op_i  = rand_op(kind);
            rd_i  = 1 + $unsigned($random(seed)) % regs;   // never x0
            rs1_i = $unsigned($random(seed)) % (regs + 1);
            rs2_i = $unsigned($random(seed)) % (regs + 1);
            opa_i = rand_word();
            opb_i = rand_word();
            if (corner && i % 2 == 0) begin
                opb_i = '0;   // divide by zero
            end else if (corner) begin
                opa_i = {1'b1, {(XLEN-1){1'b0}}};
                opb_i = '1;
            end
            inst_valid_i = 1'b1;
            took = 1'b0;
            while (!took) begin   // hold until accepted
                @(negedge clk);
                took = !stall_o;
                step_cycle();
            end
        end
        inst_valid_i = 1'b0;
    endtask

    // sample mid-cycle, mirror the next rising edge into the model
    always @(negedge clk) begin : check_outputs
        logic            fire;
        logic            hazard;
        logic [XLEN-1:0] want;
        if (rst_n) begin
            fire = wb_valid_o && wb_ready_i;
            if (hold_q && (!wb_valid_o || wb_rd_o !== prev_rd || wb_data_o !== prev_data)) begin
                $display("error %s: held writeback expected x%0d %h actual x%0d %h",
                         test_name, prev_rd, prev_data, wb_rd_o, wb_data_o);
                err_proto++;
            end
            hold_q    = wb_valid_o && !wb_ready_i;
            prev_rd   = wb_rd_o;
            prev_data = wb_data_o;
            if (busy_o !== (n_flight != 0)) begin
                $display("error %s: busy_o expected %0b actual %0b",
                         test_name, n_flight != 0, busy_o);
                err_proto++;
            end
            if (n_flight == ENTRIES && !stall_o) begin
                $display("error %s: stall_o expected 1 actual 0 with table full", test_name);
                err_hazard++;
            end
            if (inst_valid_i) begin
                hazard = (rs1_i != '0 && reg_pending(rs1_i, fire))
                      || (rs2_i != '0 && reg_pending(rs2_i, fire))
                      || (rd_we_i && rd_i != '0 && reg_pending(rd_i, fire));
                if (hazard && !stall_o) begin
                    $display("error %s: stall_o expected 1 actual 0 (rd x%0d rs x%0d x%0d)",
                             test_name, rd_i, rs1_i, rs2_i);
                    err_hazard++;
                end
            end
            if (fire && !fl_valid[wb_rd_o]) begin
                $display("error %s: writeback to x%0d with nothing in flight",
                         test_name, wb_rd_o);
                err_proto++;
            end else if (fire) begin
                want = mdu_ref(fl_op[wb_rd_o], fl_a[wb_rd_o], fl_b[wb_rd_o]);
                if (wb_data_o !== want) begin
                    $display("error %s: issue %0d x%0d op %0d expected %h actual %h",
                             test_name, fl_order[wb_rd_o], wb_rd_o, fl_op[wb_rd_o],
                             want, wb_data_o);
                    err_data++;
                end
                fl_valid[wb_rd_o] = 1'b0;
                n_flight--;
            end
            if (inst_valid_i && !stall_o) begin   // issue fires at the next edge
                if (!fl_valid[rd_i]) n_flight++;
                fl_valid[rd_i] = 1'b1;
                fl_op[rd_i]    = op_i;
                fl_a[rd_i]     = opa_i;
                fl_b[rd_i]     = opb_i;
                fl_order[rd_i] = n_issued;
                n_issued++;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run stopped after %0d cycles, %0d results outstanding",
                     cycles, n_flight);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        rst_n        = 1'b0;
        inst_valid_i = 1'b0;
        op_i         = '0;
        rd_i         = '0;
        rs1_i        = '0;
        rs2_i        = '0;
        rd_we_i      = 1'b1;   // every instruction writes a nonzero rd
        opa_i        = '0;
        opb_i        = '0;
        wb_ready_i   = 1'b1;
        for (int r = 0; r < REGS; r++) fl_valid[r] = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        if (stall_o || wb_valid_o || busy_o) begin
            $display("error reset: stall/wb_valid/busy expected 000 actual %b%b%b",
                     stall_o, wb_valid_o, busy_o);
            err_proto++;
        end
        step_cycle();
        run_phase("mul_only", 60, 0, 31, 0, 1'b0);
        run_phase("div_only", 40, 1, 31, 0, 1'b0);
        run_phase("mix_reuse", 100, 2, 4, 0, 1'b0);
        run_phase("backpressure", 60, 2, 6, 40, 1'b0);
        run_phase("div_corner", 40, 1, 8, 20, 1'b1);
        bp_pct = 0;
        while (n_flight != 0) step_cycle();   // drain, timeout guards it
        repeat (4) step_cycle();
        if (busy_o) begin
            $display("error drain: busy_o expected 0 actual 1 after all writebacks");
            err_proto++;
        end
        $display("errors: data %0d, hazard %0d, protocol %0d, issued %0d",
                 err_data, err_hazard, err_proto, n_issued);
        if (err_data + err_hazard + err_proto == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
rtl/mdu_pkg.sv
rtl/long_hazard_unit.sv
rtl/mul_unit.sv
rtl/div_unit.sv
rtl/wb_arbiter.sv
rtl/mdu_top.sv
testbench/tb_mdu_top.sv

// ==== Bender.yml ====
package:
  name: mdu

sources:
  - files:
      - rtl/mdu_pkg.sv
      - rtl/long_hazard_unit.sv
      - rtl/mul_unit.sv
      - rtl/div_unit.sv
      - rtl/wb_arbiter.sv
      - rtl/mdu_top.sv
  - target: test
    files:
      - testbench/tb_mdu_top.sv
